/* common/regPkg.sv */
`default_nettype none

package regPkg;

    localparam int DataWidth = 32;
    localparam int AddrWidth = 5;
    localparam int LaneCount = 4;
    localparam int LaneWidth = DataWidth / LaneCount;
    localparam int RegCount = 1 << AddrWidth;
    localparam int ImmWidth = 16;

    localparam int CmdDepth = 4;
    localparam int CmdPtrWidth = $clog2(CmdDepth);
    localparam int CmdCountWidth = $clog2(CmdDepth + 1);

    localparam int ResultCredits = 4;
    localparam int CreditWidth = $clog2(ResultCredits + 1);

    // LUI places the immediate in the upper half and clears the lower half.
    typedef enum logic [3:0] {
        OpAdd = 4'd0,
        OpSub = 4'd1,
        OpAnd = 4'd2,
        OpOr  = 4'd3,
        OpXor = 4'd4,
        OpSlt = 4'd5, // Signed compare that yields 0 or 1.
        OpLui = 4'd6
    } opT;

    // 40 bits in total.
    typedef struct packed {
        opT                   op;
        logic [AddrWidth-1:0] rd;
        logic [AddrWidth-1:0] rs;
        logic [AddrWidth-1:0] rt;
        logic                 useImm; // The immediate replaces rt as the second operand.
        logic [ImmWidth-1:0]  imm;
        logic [LaneCount-1:0] mask;   // Byte lanes of rd that are written back.
    } cmdT;

endpackage

`default_nettype wire

/* grf/Grf.sv */
`timescale 1ns/1ps
`default_nettype none

module Grf
    import regPkg::*;
(
    input  logic                 Clk,
    input  logic                 reset,
    input  logic [AddrWidth-1:0] Addr1,
    input  logic [AddrWidth-1:0] Addr2,
    input  logic [AddrWidth-1:0] WriteAddr,
    input  logic [LaneCount-1:0] WriteEnable,
    input  logic [DataWidth-1:0] WriteData,
    output logic [DataWidth-1:0] OutData1,
    output logic [DataWidth-1:0] OutData2
);

    logic [DataWidth-1:0] regs [RegCount];

    // A lane being written this cycle is forwarded, so a reader never sees the stale byte.
    function automatic logic [DataWidth-1:0] readPort(
        input logic [AddrWidth-1:0] addr,
        input logic [DataWidth-1:0] stored
    );
        logic [DataWidth-1:0] value;
        value = stored;
        for (int lane = 0; lane < LaneCount; lane++) begin
            if (WriteEnable[lane] && (WriteAddr == addr))
                value[lane*LaneWidth +: LaneWidth] = WriteData[lane*LaneWidth +: LaneWidth];
        end
        if (addr == '0)
            value = '0; // r0 is hardwired to zero.
        return value;
    endfunction

    always_comb begin
        OutData1 = readPort(Addr1, regs[Addr1]);
        OutData2 = readPort(Addr2, regs[Addr2]);
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            for (int i = 0; i < RegCount; i++)
                regs[i] <= '0;
        end else begin
            for (int lane = 0; lane < LaneCount; lane++) begin
                if (WriteEnable[lane])
                    regs[WriteAddr][lane*LaneWidth +: LaneWidth] <=
                        WriteData[lane*LaneWidth +: LaneWidth];
            end
        end
    end

    // The enables come from the writeback register, which must be clean once out of reset.
    assert property (@(posedge Clk) disable iff (reset) !$isunknown(WriteEnable))
        else $error("Grf: WriteEnable is unknown");

endmodule

`default_nettype wire

/* source/CmdQueue.sv */
`timescale 1ns/1ps
`default_nettype none

module CmdQueue
    import regPkg::*;
(
    input  logic Clk,
    input  logic reset,
    input  logic CmdValid,
    input  cmdT  CmdIn,
    input  logic Pop,
    output cmdT  Head,
    output logic NonEmpty,
    output logic CmdCredit
);

    cmdT                      mem [CmdDepth];
    logic [CmdPtrWidth-1:0]   wrPtr;
    logic [CmdPtrWidth-1:0]   rdPtr;
    logic [CmdCountWidth-1:0] count;
    logic                     full;

    assign Head = mem[rdPtr];
    assign NonEmpty = (count != '0);
    assign full = (count == CmdCountWidth'(CmdDepth));

    always_ff @(posedge Clk) begin
        if (CmdValid)
            mem[wrPtr] <= CmdIn;
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
            CmdCredit <= 1'b0;
        end else begin
            CmdCredit <= Pop; // Each freed slot goes back to the sender as one credit.
            if (CmdValid)
                wrPtr <= (wrPtr == CmdPtrWidth'(CmdDepth - 1)) ? '0 : wrPtr + 1'b1;
            if (Pop)
                rdPtr <= (rdPtr == CmdPtrWidth'(CmdDepth - 1)) ? '0 : rdPtr + 1'b1;
            case ({CmdValid, Pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // A push into a full queue means the sender spent a credit it did not hold.
    assert property (@(posedge Clk) disable iff (reset) !(CmdValid && full))
        else $error("CmdQueue: push while full");

    assert property (@(posedge Clk) disable iff (reset) Pop |-> NonEmpty)
        else $error("CmdQueue: pop while empty");

endmodule

`default_nettype wire

/* source/IssueStage.sv */
`timescale 1ns/1ps
`default_nettype none

module IssueStage
    import regPkg::*;
(
    input  logic                 Clk,
    input  logic                 reset,
    input  cmdT                  Head,
    input  logic                 NonEmpty,
    output logic                 Pop,
    input  logic                 ResultCredit,
    input  logic [AddrWidth-1:0] ExRd,
    input  logic                 ExValid,
    output logic [AddrWidth-1:0] ReadAddr1,
    output logic [AddrWidth-1:0] ReadAddr2,
    input  logic [DataWidth-1:0] ReadData1,
    input  logic [DataWidth-1:0] ReadData2,
    output logic                 IssValid,
    output cmdT                  IssCmd,
    output logic [DataWidth-1:0] IssOpA,
    output logic [DataWidth-1:0] IssOpB
);

    logic [CreditWidth-1:0] creditCount;
    logic                   rsHazard;
    logic                   rtHazard;
    logic                   hazard;
    logic [DataWidth-1:0]   immExt;

    assign ReadAddr1 = Head.rs;
    assign ReadAddr2 = Head.rt;

    // Only the instruction in execute can conflict. Anything older is covered by the
    // writeback bypass in the register file.
    assign rsHazard = (ExRd == Head.rs);
    assign rtHazard = (ExRd == Head.rt) && !Head.useImm;
    assign hazard = ExValid && (ExRd != '0) && (rsHazard || rtHazard);

    assign Pop = NonEmpty && (creditCount != '0) && !hazard;

    assign immExt = {{(DataWidth - ImmWidth){Head.imm[ImmWidth-1]}}, Head.imm};

    always_ff @(posedge Clk) begin
        if (reset) begin
            creditCount <= CreditWidth'(ResultCredits);
        end else begin
            case ({ResultCredit, Pop})
                2'b10: creditCount <= creditCount + 1'b1;
                2'b01: creditCount <= creditCount - 1'b1;
                default: creditCount <= creditCount;
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (reset)
            IssValid <= 1'b0;
        else
            IssValid <= Pop;
    end

    always_ff @(posedge Clk) begin
        IssCmd <= Head;
        IssOpA <= ReadData1;
        IssOpB <= Head.useImm ? immExt : ReadData2;
    end

    // The consumer never grants more than it started with, since every result it
    // returns a credit for was issued against one.
    assert property (@(posedge Clk) disable iff (reset)
        creditCount <= CreditWidth'(ResultCredits))
        else $error("IssueStage: result credit overflow");

endmodule

`default_nettype wire

/* source/ExecUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module ExecUnit
    import regPkg::*;
(
    input  logic                 Clk,
    input  logic                 reset,
    input  logic                 IssValid,
    input  cmdT                  IssCmd,
    input  logic [DataWidth-1:0] IssOpA,
    input  logic [DataWidth-1:0] IssOpB,
    output logic                 ExValid,
    output logic [AddrWidth-1:0] ExRd,
    output logic [AddrWidth-1:0] WriteAddr,
    output logic [LaneCount-1:0] WriteEnable,
    output logic [DataWidth-1:0] WriteData,
    output logic                 ResultValid,
    output logic [AddrWidth-1:0] ResultRd,
    output logic [DataWidth-1:0] ResultData,
    output logic [LaneCount-1:0] ResultMask
);

    logic [DataWidth-1:0] aluResult;
    logic                 wbValid;
    logic [AddrWidth-1:0] wbRd;
    logic [LaneCount-1:0] wbMask;
    logic [DataWidth-1:0] wbData;

    // The operands sit in the issue registers, so the execute stage is this ALU.
    always_comb begin
        case (IssCmd.op)
            OpAdd: aluResult = IssOpA + IssOpB;
            OpSub: aluResult = IssOpA - IssOpB;
            OpAnd: aluResult = IssOpA & IssOpB;
            OpOr:  aluResult = IssOpA | IssOpB;
            OpXor: aluResult = IssOpA ^ IssOpB;
            OpSlt: aluResult = {{(DataWidth - 1){1'b0}}, $signed(IssOpA) < $signed(IssOpB)};
            OpLui: aluResult = {IssCmd.imm, {(DataWidth - ImmWidth){1'b0}}};
            default: aluResult = '0;
        endcase
    end

    assign ExValid = IssValid;
    assign ExRd = IssCmd.rd;

    always_ff @(posedge Clk) begin
        if (reset)
            wbValid <= 1'b0;
        else
            wbValid <= IssValid;
    end

    always_ff @(posedge Clk) begin
        wbRd <= IssCmd.rd;
        wbMask <= IssCmd.mask;
        wbData <= aluResult;
    end

    assign WriteAddr = wbRd;
    assign WriteEnable = wbValid ? wbMask : '0;
    assign WriteData = wbData;

    // The full result is reported while the mask only limits what lands in the register file.
    assign ResultValid = wbValid;
    assign ResultRd = wbRd;
    assign ResultData = wbData;
    assign ResultMask = wbMask;

endmodule

`default_nettype wire

/* source/RegExecTop.sv */
`timescale 1ns/1ps
`default_nettype none

module RegExecTop
    import regPkg::*;
(
    input  logic                 Clk,
    input  logic                 reset,
    input  logic                 CmdValid,
    input  opT                   CmdOp,
    input  logic [AddrWidth-1:0] CmdRd,
    input  logic [AddrWidth-1:0] CmdRs,
    input  logic [AddrWidth-1:0] CmdRt,
    input  logic                 CmdUseImm,
    input  logic [ImmWidth-1:0]  CmdImm,
    input  logic [LaneCount-1:0] CmdMask,
    output logic                 CmdCredit,
    input  logic                 ResultCredit,
    output logic                 ResultValid,
    output logic [AddrWidth-1:0] ResultRd,
    output logic [DataWidth-1:0] ResultData,
    output logic [LaneCount-1:0] ResultMask
);

    cmdT                  cmdIn;
    cmdT                  head;
    logic                 nonEmpty;
    logic                 pop;
    logic [AddrWidth-1:0] exRd;
    logic                 exValid;
    logic [AddrWidth-1:0] readAddr1;
    logic [AddrWidth-1:0] readAddr2;
    logic [DataWidth-1:0] readData1;
    logic [DataWidth-1:0] readData2;
    logic                 issValid;
    cmdT                  issCmd;
    logic [DataWidth-1:0] issOpA;
    logic [DataWidth-1:0] issOpB;
    logic [AddrWidth-1:0] writeAddr;
    logic [LaneCount-1:0] writeEnable;
    logic [DataWidth-1:0] writeData;

    assign cmdIn = '{
        op:     CmdOp,
        rd:     CmdRd,
        rs:     CmdRs,
        rt:     CmdRt,
        useImm: CmdUseImm,
        imm:    CmdImm,
        mask:   CmdMask
    };

    CmdQueue queue (
        .Clk(Clk), .reset(reset),
        .CmdValid(CmdValid), .CmdIn(cmdIn),
        .Pop(pop), .Head(head), .NonEmpty(nonEmpty),
        .CmdCredit(CmdCredit)
    );

    IssueStage issue (
        .Clk(Clk), .reset(reset),
        .Head(head), .NonEmpty(nonEmpty), .Pop(pop),
        .ResultCredit(ResultCredit),
        .ExRd(exRd), .ExValid(exValid),
        .ReadAddr1(readAddr1), .ReadAddr2(readAddr2),
        .ReadData1(readData1), .ReadData2(readData2),
        .IssValid(issValid), .IssCmd(issCmd),
        .IssOpA(issOpA), .IssOpB(issOpB)
    );

    ExecUnit exec (
        .Clk(Clk), .reset(reset),
        .IssValid(issValid), .IssCmd(issCmd),
        .IssOpA(issOpA), .IssOpB(issOpB),
        .ExValid(exValid), .ExRd(exRd),
        .WriteAddr(writeAddr), .WriteEnable(writeEnable), .WriteData(writeData),
        .ResultValid(ResultValid), .ResultRd(ResultRd),
        .ResultData(ResultData), .ResultMask(ResultMask)
    );

    Grf grf (
        .Clk(Clk), .reset(reset),
        .Addr1(readAddr1), .Addr2(readAddr2),
        .WriteAddr(writeAddr), .WriteEnable(writeEnable), .WriteData(writeData),
        .OutData1(readData1), .OutData2(readData2)
    );

endmodule

`default_nettype wire

/* sim/RegExecTb.sv */
`timescale 1ns/1ps
`default_nettype none

module RegExecTb
    import regPkg::*;
();

    localparam int MaxCmds = 64;
    localparam int TimeoutCycles = 200;

    logic                 Clk;
    logic                 reset;
    logic                 CmdValid;
    opT                   CmdOp;
    logic [AddrWidth-1:0] CmdRd;
    logic [AddrWidth-1:0] CmdRs;
    logic [AddrWidth-1:0] CmdRt;
    logic                 CmdUseImm;
    logic [ImmWidth-1:0]  CmdImm;
    logic [LaneCount-1:0] CmdMask;
    logic                 CmdCredit;
    logic                 ResultCredit;
    logic                 ResultValid;
    logic [AddrWidth-1:0] ResultRd;
    logic [DataWidth-1:0] ResultData;
    logic [LaneCount-1:0] ResultMask;

    opT                   patOp [MaxCmds];
    logic [31:0]          patName [MaxCmds];
    logic [AddrWidth-1:0] patRd [MaxCmds];
    logic [AddrWidth-1:0] patRs [MaxCmds];
    logic [AddrWidth-1:0] patRt [MaxCmds];
    logic                 patUseImm [MaxCmds];
    logic [ImmWidth-1:0]  patImm [MaxCmds];
    logic [LaneCount-1:0] patMask [MaxCmds];
    int                   patHold [MaxCmds];
    logic [DataWidth-1:0] patExpect [MaxCmds];
    int                   patCount = 0;

    logic [DataWidth-1:0] refRegs [RegCount]; // Register contents as the rules predict them.

    int   cycle = 0;
    int   holdUntil = 0; // Result credits are withheld until this cycle.
    int   sentCount = 0;
    int   cmdCreditsBack = 0;
    int   resultCount = 0;
    int   creditsReturned = 0;
    int   owedCredits = 0;
    int   mismatchCount = 0;
    int   otherErrors = 0;
    logic creditDue = 1'b0;
    logic started = 1'b0;
    logic timedOut = 1'b0;

    RegExecTop DUT (
        .Clk(Clk), .reset(reset),
        .CmdValid(CmdValid), .CmdOp(CmdOp),
        .CmdRd(CmdRd), .CmdRs(CmdRs), .CmdRt(CmdRt),
        .CmdUseImm(CmdUseImm), .CmdImm(CmdImm), .CmdMask(CmdMask),
        .CmdCredit(CmdCredit), .ResultCredit(ResultCredit),
        .ResultValid(ResultValid), .ResultRd(ResultRd),
        .ResultData(ResultData), .ResultMask(ResultMask)
    );

    initial begin
        Clk = 1'b0;
        forever #4 Clk = ~Clk;
    end

    always @(posedge Clk) cycle <= cycle + 1;

    function automatic int opCode(input logic [31:0] name);
        case (name)
            "ADD": return int'(OpAdd);
            "SUB": return int'(OpSub);
            "AND": return int'(OpAnd);
            "OR":  return int'(OpOr);
            "XOR": return int'(OpXor);
            "SLT": return int'(OpSlt);
            "LUI": return int'(OpLui);
            default: return -1;
        endcase
    endfunction

    task automatic loadPatterns();
        int                   fd;
        int                   fields;
        int                   code;
        string                line;
        logic [31:0]          opName;
        int                   rd;
        int                   rs;
        int                   rt;
        int                   useImm;
        int                   hold;
        logic [ImmWidth-1:0]  imm;
        logic [LaneCount-1:0] mask;
        logic [DataWidth-1:0] expected;
        fd = $fopen("sim/regExecPatterns.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the pattern file sim/regExecPatterns.txt");
            otherErrors++;
            return;
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() < 2 || line[0] == "#")
                continue;
            fields = $sscanf(line, "%s %d %d %d %d %h %h %d %h", opName, rd, rs, rt,
                             useImm, imm, mask, hold, expected);
            code = opCode(opName);
            if (fields != 9 || code < 0 || patCount == MaxCmds) begin
                $display("Pattern line cannot be used: %s", line);
                otherErrors++;
            end else begin
                patOp[patCount] = opT'(code[3:0]);
                patName[patCount] = opName;
                patRd[patCount] = rd[AddrWidth-1:0];
                patRs[patCount] = rs[AddrWidth-1:0];
                patRt[patCount] = rt[AddrWidth-1:0];
                patUseImm[patCount] = (useImm != 0);
                patImm[patCount] = imm;
                patMask[patCount] = mask;
                patHold[patCount] = hold;
                patExpect[patCount] = expected;
                patCount++;
            end
        end
        $fclose(fd);
    endtask

    task automatic sendCommand(input int idx);
        CmdValid = 1'b1;
        CmdOp = patOp[idx];
        CmdRd = patRd[idx];
        CmdRs = patRs[idx];
        CmdRt = patRt[idx];
        CmdUseImm = patUseImm[idx];
        CmdImm = patImm[idx];
        CmdMask = patMask[idx];
        sentCount++; // One credit spent per valid cycle.
        @(posedge Clk);
        #1;
        CmdValid = 1'b0;
    endtask

    task automatic runSender();
        int idle;
        for (int i = 0; i < patCount; i++) begin
            if (patHold[i] > 0)
                holdUntil = cycle + patHold[i];
            idle = 0;
            while (sentCount - cmdCreditsBack >= CmdDepth && !timedOut) begin
                @(posedge Clk);
                #1;
                idle++;
                if (idle > TimeoutCycles) begin
                    $display("Timeout: no command credit came back for %0d cycles", idle);
                    otherErrors++;
                    timedOut = 1'b1;
                end
            end
            if (timedOut)
                return;
            sendCommand(i);
        end
    endtask

    task automatic compareValue(input string name, input logic [DataWidth-1:0] expected,
                                input logic [DataWidth-1:0] actual);
        assert (actual === expected) else begin
            $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
            mismatchCount++;
        end
    endtask

    task automatic checkResult();
        int    idx;
        string name;
        idx = resultCount;
        assert (resultCount < ResultCredits + creditsReturned) else begin
            $display("ResultValid rose without a result credit at result %0d", idx);
            otherErrors++;
        end
        assert (idx < patCount) else begin
            $display("A result arrived after the last command, rd %0d", ResultRd);
            otherErrors++;
        end
        if (idx < patCount) begin
            name = $sformatf("command %0d (%0s r%0d)", idx, patName[idx], patRd[idx]);
            compareValue({name, " data"}, patExpect[idx], ResultData);
            compareValue({name, " rd"}, DataWidth'(patRd[idx]), DataWidth'(ResultRd));
            compareValue({name, " mask"}, DataWidth'(patMask[idx]), DataWidth'(ResultMask));
            // An OR with r0 reads a register back unchanged.
            if (patOp[idx] == OpOr && !patUseImm[idx] && patRt[idx] == '0)
                compareValue({name, " readback"}, refRegs[patRs[idx]], ResultData);
            if (patRd[idx] != '0) begin
                for (int lane = 0; lane < LaneCount; lane++) begin
                    if (patMask[idx][lane])
                        refRegs[patRd[idx]][lane*LaneWidth +: LaneWidth] =
                            patExpect[idx][lane*LaneWidth +: LaneWidth];
                end
            end
        end
        resultCount++;
    endtask

    // Outputs are sampled mid-cycle, where they are stable.
    always @(negedge Clk) begin
        if (!reset) begin
            if (!started) begin
                assert (!CmdCredit && !ResultValid) else begin
                    $display("CmdCredit or ResultValid rose before any command was sent");
                    otherErrors++;
                end
            end
            if (CmdCredit) begin
                assert (cmdCreditsBack < sentCount) else begin
                    $display("CmdCredit returned more credits than commands were sent");
                    otherErrors++;
                end
                cmdCreditsBack++;
            end
            if (ResultValid) begin
                checkResult();
                owedCredits++;
            end
            creditDue = (cycle >= holdUntil) && (owedCredits > 0);
            if (creditDue)
                owedCredits--;
        end
    end

    initial begin
        forever begin
            @(posedge Clk);
            #1;
            ResultCredit = creditDue;
            if (creditDue)
                creditsReturned++;
        end
    end

    initial begin
        int idle;
        int lastCount;
        reset = 1'b1;
        CmdValid = 1'b0;
        CmdOp = OpAdd;
        CmdRd = '0;
        CmdRs = '0;
        CmdRt = '0;
        CmdUseImm = 1'b0;
        CmdImm = '0;
        CmdMask = '0;
        ResultCredit = 1'b0;
        for (int r = 0; r < RegCount; r++)
            refRegs[r] = '0;
        loadPatterns();
        repeat (4) @(posedge Clk);
        #1;
        reset = 1'b0;
        repeat (3) @(posedge Clk); // Idle outputs are watched here.
        #1;
        if (patCount == 0) begin
            $display("The pattern file holds no usable command");
            otherErrors++;
        end else begin
            started = 1'b1;
            fork
                runSender();
            join_none
            idle = 0;
            lastCount = 0;
            while (resultCount < patCount && !timedOut) begin
                @(posedge Clk);
                #1;
                if (resultCount != lastCount) begin
                    lastCount = resultCount;
                    idle = 0;
                end else begin
                    idle++;
                end
                if (idle > TimeoutCycles) begin
                    $display("Timeout: %0d of %0d results arrived", resultCount, patCount);
                    otherErrors++;
                    timedOut = 1'b1;
                end
            end
            repeat (8) @(posedge Clk);
        end
        $display("Errors: %0d mismatches, %0d other failures, %0d of %0d results seen",
                 mismatchCount, otherErrors, resultCount, patCount);
        if (mismatchCount == 0 && otherErrors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/regExecPatterns.txt */
# op  rd rs rt useImm imm  mask hold expected
# rd, rs, rt, useImm and hold are decimal; imm, mask and expected are hex.
# Reset state and r0 reads.
OR    1  0  0  0  0000 F 0  00000000
ADD   2  5  6  0  0000 F 0  00000000
# Immediate arithmetic with sign extension.
ADD   1  0  0  1  1234 F 0  00001234
ADD   3  0  0  1  FFFF F 0  FFFFFFFF
SUB   4  1  0  1  0034 F 0  00001200
AND   5  3  0  1  8F0F F 0  FFFF8F0F
OR    6  4  0  1  00AB F 0  000012AB
XOR   7  5  0  1  FFFF F 0  000070F0
SLT   8  3  0  1  0000 F 0  00000001
SLT   9  1  0  1  FFFE F 0  00000000
LUI   10 0  0  1  ABCD F 0  ABCD0000
SUB   11 0  1  0  0000 F 0  FFFFEDCC
SLT   12 11 1  0  0000 F 0  00000001
ADD   0  1  1  0  0000 F 0  00002468
OR    13 0  0  0  0000 F 0  00000000
# Byte-lane writeback, then readback with OR r0.
LUI   14 0  0  1  1122 F 0  11220000
ADD   14 0  0  1  3344 3 0  00003344
OR    15 14 0  0  0000 F 0  11223344
XOR   14 0  0  1  FFFF 4 0  FFFFFFFF
OR    16 14 0  0  0000 F 0  11FF3344
LUI   17 0  0  1  DEAD 8 0  DEAD0000
ADD   17 0  0  1  00BE 1 0  000000BE
OR    18 17 0  0  0000 F 0  DE0000BE
ADD   19 0  0  1  7777 0 0  00007777
OR    20 19 0  0  0000 F 0  00000000
# Back-to-back dependence chain.
ADD   21 0  0  1  0001 F 0  00000001
ADD   21 21 21 0  0000 F 0  00000002
ADD   21 21 21 0  0000 F 0  00000004
SUB   22 21 0  1  0005 F 0  FFFFFFFF
XOR   23 22 21 0  0000 F 0  FFFFFFFB
SLT   24 23 22 0  0000 F 0  00000001
# Result credits withheld, queue fills up behind them.
ADD   25 0  0  1  0010 F 24 00000010
ADD   25 25 0  1  0010 F 0  00000020
ADD   25 25 0  1  0010 F 0  00000030
ADD   25 25 0  1  0010 F 0  00000040
ADD   25 25 0  1  0010 F 0  00000050
ADD   25 25 0  1  0010 F 0  00000060
OR    26 25 0  0  0000 F 0  00000060
AND   27 26 14 0  0000 F 0  00000040
OR    28 14 0  0  0000 F 12 11FF3344
OR    29 17 0  0  0000 F 0  DE0000BE

/* sim.f */
common/regPkg.sv
grf/Grf.sv
source/CmdQueue.sv
source/IssueStage.sv
source/ExecUnit.sv
source/RegExecTop.sv
sim/RegExecTb.sv
